// File: flist.f
source/npc_pkg.sv
source/npc_regfile.sv
source/npc_ifu.sv
source/npc_idu.sv
source/npc_exu.sv
source/npc_wbu.sv
source/npc_core.sv
verification/npc_asserts.sv
verification/npc_tb.sv

// File: Makefile
# Verilator flow for the npc core

VERILATOR ?= verilator
TOP       ?= npc_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= TEST FAILED
PASS_MSG  ?= TEST PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verification/npc_tb.sv
// npc core testbench
`timescale 1ns/100ps

module npc_tb;
	import npc_pkg::*;

	localparam int IMEM_WORDS  = 64;
	localparam int MAX_ENTRIES = 64;

	logic     clk;
	logic     rst;
	pc_t      inst_addr;
	inst_t    inst_data;
	logic     commit_valid;
	pc_t      commit_pc;
	logic     commit_wen;
	reg_idx_t commit_rd;
	xlen_t    commit_data;
	logic     illegal;

	// program image, word 0 sits at RESET_PC
	inst_t    imem [0:IMEM_WORDS-1];
	pc_t      img_off;
	// commit table
	pc_t      tbl_pc   [MAX_ENTRIES];
	logic     tbl_wen  [MAX_ENTRIES];
	reg_idx_t tbl_rd   [MAX_ENTRIES];
	xlen_t    tbl_data [MAX_ENTRIES];
	pc_t      tbl_npc  [MAX_ENTRIES];
	int       n_entries;
	int       cycles;

	npc_core DUT (
		.clk          (clk),
		.rst          (rst),
		.inst_addr    (inst_addr),
		.inst_data    (inst_data),
		.commit_valid (commit_valid),
		.commit_pc    (commit_pc),
		.commit_wen   (commit_wen),
		.commit_rd    (commit_rd),
		.commit_data  (commit_data),
		.illegal      (illegal)
	);

	// combinational imem, outside the image reads zero
	// opcode 0 is illegal so a stray fetch halts the core
	assign img_off   = inst_addr - RESET_PC;
	assign inst_data = (img_off[63:8] == '0) ? imem[img_off[7:2]] : '0;

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// edges since reset release
	always @(posedge clk) begin
		if (rst) begin
			cycles <= 0;
		end else begin
			cycles <= cycles + 1;
		end
	end

	// ****************************************
	// instruction encoders
	// ****************************************
	function automatic inst_t i_word(logic [6:0] opc, logic [2:0] f3, reg_idx_t rd,
		reg_idx_t rs1, logic [11:0] imm);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic inst_t imm_op(logic [2:0] f3, reg_idx_t rd, reg_idx_t rs1,
		logic [11:0] imm);
		return i_word(OPC_OP_IMM, f3, rd, rs1, imm);
	endfunction

	function automatic inst_t reg_op(logic [6:0] f7, logic [2:0] f3, reg_idx_t rd,
		reg_idx_t rs1, reg_idx_t rs2);
		return {f7, rs2, rs1, f3, rd, OPC_OP};
	endfunction

	function automatic inst_t upper_op(logic [6:0] opc, reg_idx_t rd, logic [19:0] imm);
		return {imm, rd, opc};
	endfunction

	// b-type offset scattered over both ends of the word
	function automatic inst_t branch_op(logic [2:0] f3, reg_idx_t rs1, reg_idx_t rs2,
		logic [12:0] off);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
	endfunction

	function automatic inst_t jal_op(reg_idx_t rd, logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
	endfunction

	// places the word in imem and records what its commit must look like
	task automatic add_entry(logic [7:0] off, inst_t inst, logic wen, reg_idx_t rd,
		xlen_t data, logic [7:0] nxt);
		tbl_pc[n_entries]   = RESET_PC + pc_t'(off);
		tbl_wen[n_entries]  = wen;
		tbl_rd[n_entries]   = rd;
		tbl_data[n_entries] = data;
		tbl_npc[n_entries]  = RESET_PC + pc_t'(nxt);
		imem[off[7:2]]      = inst;
		n_entries           = n_entries + 1;
	endtask

	task automatic check_value(string what, xlen_t got, xlen_t exp);
		if (got !== exp) begin
			$display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
			$display("TEST FAILED");
			$fatal(1, "mismatch on %s", what);
		end
	endtask

	task automatic await_commit();
		do begin
			@(negedge clk);
		end while (!commit_valid);
	endtask

	// ****************************************
	// program and commit table
	// ****************************************
	initial begin
		int quiet;
		rst       = 1'b1;
		n_entries = 0;
		quiet     = 0;
		for (int i = 0; i < IMEM_WORDS; i++) begin
			imem[i] = '0;
		end
		// columns: pc offset, instruction, wen, rd, data, next pc offset
		// op-imm group, x1 = 5, x2 = -3
		add_entry(8'h00, imm_op(3'd0, 5'd1, 5'd0, 12'd5), 1'b1, 5'd1, 64'd5, 8'h04);
		add_entry(8'h04, imm_op(3'd0, 5'd2, 5'd1, 12'hFF8), 1'b1, 5'd2, 64'hFFFFFFFFFFFFFFFD, 8'h08);
		add_entry(8'h08, imm_op(3'd2, 5'd3, 5'd2, 12'hFFE), 1'b1, 5'd3, 64'd1, 8'h0C);
		add_entry(8'h0C, imm_op(3'd3, 5'd4, 5'd2, 12'd7), 1'b1, 5'd4, 64'd0, 8'h10);
		add_entry(8'h10, imm_op(3'd4, 5'd5, 5'd1, 12'h0F0), 1'b1, 5'd5, 64'hF5, 8'h14);
		add_entry(8'h14, imm_op(3'd6, 5'd6, 5'd5, 12'hF00), 1'b1, 5'd6, 64'hFFFFFFFFFFFFFFF5, 8'h18);
		add_entry(8'h18, imm_op(3'd7, 5'd7, 5'd6, 12'h7FF), 1'b1, 5'd7, 64'h7F5, 8'h1C);
		add_entry(8'h1C, imm_op(3'd1, 5'd8, 5'd1, 12'd40), 1'b1, 5'd8, 64'h0000050000000000, 8'h20);
		add_entry(8'h20, imm_op(3'd5, 5'd9, 5'd2, 12'd60), 1'b1, 5'd9, 64'hF, 8'h24);
		add_entry(8'h24, imm_op(3'd5, 5'd10, 5'd2, 12'h401), 1'b1, 5'd10, 64'hFFFFFFFFFFFFFFFE, 8'h28);
		// write to x0 is dropped, next add sees zero
		add_entry(8'h28, imm_op(3'd0, 5'd0, 5'd1, 12'd7), 1'b0, 5'd0, 64'd0, 8'h2C);
		// op group, each reads the previous result
		add_entry(8'h2C, reg_op(7'h00, 3'd0, 5'd11, 5'd0, 5'd1), 1'b1, 5'd11, 64'd5, 8'h30);
		add_entry(8'h30, reg_op(7'h20, 3'd0, 5'd12, 5'd0, 5'd11), 1'b1, 5'd12, 64'hFFFFFFFFFFFFFFFB, 8'h34);
		add_entry(8'h34, reg_op(7'h00, 3'd1, 5'd13, 5'd12, 5'd1), 1'b1, 5'd13, 64'hFFFFFFFFFFFFFF60, 8'h38);
		add_entry(8'h38, reg_op(7'h00, 3'd2, 5'd14, 5'd13, 5'd1), 1'b1, 5'd14, 64'd1, 8'h3C);
		add_entry(8'h3C, reg_op(7'h00, 3'd3, 5'd15, 5'd14, 5'd13), 1'b1, 5'd15, 64'd1, 8'h40);
		add_entry(8'h40, reg_op(7'h00, 3'd4, 5'd16, 5'd15, 5'd13), 1'b1, 5'd16, 64'hFFFFFFFFFFFFFF61, 8'h44);
		add_entry(8'h44, reg_op(7'h20, 3'd5, 5'd17, 5'd16, 5'd1), 1'b1, 5'd17, 64'hFFFFFFFFFFFFFFFB, 8'h48);
		add_entry(8'h48, reg_op(7'h00, 3'd5, 5'd18, 5'd17, 5'd1), 1'b1, 5'd18, 64'h07FFFFFFFFFFFFFF, 8'h4C);
		add_entry(8'h4C, reg_op(7'h00, 3'd6, 5'd19, 5'd18, 5'd13), 1'b1, 5'd19, 64'hFFFFFFFFFFFFFFFF, 8'h50);
		add_entry(8'h50, reg_op(7'h00, 3'd7, 5'd20, 5'd19, 5'd8), 1'b1, 5'd20, 64'h0000050000000000, 8'h54);
		// upper immediates
		add_entry(8'h54, upper_op(OPC_LUI, 5'd21, 20'h80001), 1'b1, 5'd21, 64'hFFFFFFFF80001000, 8'h58);
		add_entry(8'h58, upper_op(OPC_AUIPC, 5'd22, 20'h12345), 1'b1, 5'd22, 64'h92345058, 8'h5C);
		// branches, taken then untaken for each condition
		add_entry(8'h5C, branch_op(3'd0, 5'd1, 5'd11, 13'd8), 1'b0, 5'd0, 64'd0, 8'h64);
		add_entry(8'h64, branch_op(3'd0, 5'd1, 5'd2, 13'd8), 1'b0, 5'd0, 64'd0, 8'h68);
		add_entry(8'h68, branch_op(3'd1, 5'd1, 5'd2, 13'd8), 1'b0, 5'd0, 64'd0, 8'h70);
		add_entry(8'h70, branch_op(3'd1, 5'd1, 5'd11, 13'd8), 1'b0, 5'd0, 64'd0, 8'h74);
		add_entry(8'h74, branch_op(3'd4, 5'd2, 5'd1, 13'd8), 1'b0, 5'd0, 64'd0, 8'h7C);
		add_entry(8'h7C, branch_op(3'd4, 5'd1, 5'd2, 13'd8), 1'b0, 5'd0, 64'd0, 8'h80);
		add_entry(8'h80, branch_op(3'd5, 5'd1, 5'd2, 13'd8), 1'b0, 5'd0, 64'd0, 8'h88);
		add_entry(8'h88, branch_op(3'd5, 5'd2, 5'd1, 13'd8), 1'b0, 5'd0, 64'd0, 8'h8C);
		add_entry(8'h8C, branch_op(3'd6, 5'd1, 5'd2, 13'd8), 1'b0, 5'd0, 64'd0, 8'h94);
		add_entry(8'h94, branch_op(3'd6, 5'd2, 5'd1, 13'd8), 1'b0, 5'd0, 64'd0, 8'h98);
		add_entry(8'h98, branch_op(3'd7, 5'd2, 5'd1, 13'd8), 1'b0, 5'd0, 64'd0, 8'hA0);
		add_entry(8'hA0, branch_op(3'd7, 5'd1, 5'd2, 13'd8), 1'b0, 5'd0, 64'd0, 8'hA4);
		// jumps, jalr target has bit 0 set before masking
		add_entry(8'hA4, jal_op(5'd23, 21'h1C), 1'b1, 5'd23, 64'h800000A8, 8'hC0);
		add_entry(8'hC0, i_word(OPC_JALR, 3'd0, 5'd24, 5'd23, 12'h021), 1'b1, 5'd24, 64'h800000C4, 8'hC8);
		// ld, not supported
		add_entry(8'hC8, i_word(7'b0000011, 3'd3, 5'd5, 5'd0, 12'd0), 1'b0, 5'd0, 64'd0, 8'hCC);

		repeat (4) @(posedge clk);
		rst <= 1'b0;

		// every entry but the last must commit, one per 4 cycles
		for (int i = 0; i < n_entries - 1; i++) begin
			await_commit();
			check_value("commit_pc", commit_pc, tbl_pc[i]);
			check_value("commit cycle", xlen_t'(cycles), xlen_t'(4 * (i + 1)));
			check_value("commit_wen", xlen_t'(commit_wen), xlen_t'(tbl_wen[i]));
			if (tbl_wen[i]) begin
				check_value("commit_rd", xlen_t'(commit_rd), xlen_t'(tbl_rd[i]));
				check_value("commit_data", commit_data, tbl_data[i]);
			end
			// pc already reloaded when the commit shows
			check_value("next pc", inst_addr, tbl_npc[i]);
			check_value("illegal", xlen_t'(illegal), 64'd0);
		end

		// last word traps at decode
		while (!illegal && (quiet < 12)) begin
			@(negedge clk);
			check_value("commit_valid", xlen_t'(commit_valid), 64'd0);
			quiet = quiet + 1;
		end
		check_value("illegal", xlen_t'(illegal), 64'd1);
		repeat (12) begin
			@(negedge clk);
			check_value("commit_valid", xlen_t'(commit_valid), 64'd0);
			check_value("illegal", xlen_t'(illegal), 64'd1);
		end

		$display("TEST PASSED");
		$finish;
	end

	// watchdog, sized from the table length
	initial begin
		@(negedge rst);
		repeat (4 * n_entries + 20) @(posedge clk);
		$display("watchdog expired, the program did not finish in time");
		$display("TEST FAILED");
		$fatal(1, "timeout");
	end

endmodule

// File: verification/npc_asserts.sv
// commit and fetch checks
`timescale 1ns/100ps

module npc_asserts (
	input logic              clk,
	input logic              rst,
	input npc_pkg::pc_t      inst_addr,
	input logic              pc_update,
	input logic              commit_valid,
	input logic              commit_wen,
	input npc_pkg::reg_idx_t commit_rd,
	input logic              illegal
);

	// ****************************************
	// commit port
	// ****************************************
	// one instruction in flight, so pulses never touch
	commit_single: assert property (@(posedge clk) disable iff (rst)
		commit_valid |=> !commit_valid)
		else $error("commit_valid high on two consecutive cycles");

	// x0 writes are reported with wen low
	commit_x0: assert property (@(posedge clk) disable iff (rst)
		commit_wen |-> (commit_rd != 5'd0))
		else $error("commit_wen set for rd x0");

	// ****************************************
	// fetch side
	// ****************************************
	// halt is sticky
	illegal_sticky: assert property (@(posedge clk) disable iff (rst)
		illegal |=> illegal)
		else $error("illegal dropped after being raised");

	// pc moves only on the exu update
	addr_hold: assert property (@(posedge clk) disable iff (rst)
		!$stable(inst_addr) |-> $past(pc_update))
		else $error("inst_addr changed without pc_update");

endmodule

bind npc_core npc_asserts u_asserts (
	.clk          (clk),
	.rst          (rst),
	.inst_addr    (inst_addr),
	.pc_update    (pc_update),
	.commit_valid (commit_valid),
	.commit_wen   (commit_wen),
	.commit_rd    (commit_rd),
	.illegal      (illegal)
);

// File: source/npc_core.sv
// npc rv64i core top
`timescale 1ns/100ps

module npc_core (
	input  logic              clk,
	input  logic              rst,
	output npc_pkg::pc_t      inst_addr,
	input  npc_pkg::inst_t    inst_data,
	output logic              commit_valid,
	output npc_pkg::pc_t      commit_pc,
	output logic              commit_wen,
	output npc_pkg::reg_idx_t commit_rd,
	output npc_pkg::xlen_t    commit_data,
	output logic              illegal
);
	import npc_pkg::*;

	// ****************************************
	// stage links
	// ****************************************
	// if -> id
	logic     valid_if_id;
	logic     ready_if_id;
	pc_t      pc_if_id;
	inst_t    inst_if_id;
	// id -> ex
	logic     valid_id_ex;
	logic     ready_id_ex;
	pc_t      pc_id_ex;
	xlen_t    op_a;
	xlen_t    op_b;
	xlen_t    imm;
	alu_op_e  alu_op;
	reg_idx_t rd;
	logic     is_branch;
	logic     is_jal;
	logic     is_jalr;
	logic [2:0] funct3;
	// ex -> if
	pc_t      dnpc;
	logic     pc_update;
	// ex -> wb
	logic     valid_ex_wb;
	logic     ready_ex_wb;
	pc_t      pc_ex_wb;
	logic     wb_wen;
	reg_idx_t wb_rd;
	xlen_t    wb_data;
	// register file ports
	reg_idx_t rs1_addr;
	reg_idx_t rs2_addr;
	xlen_t    rs1_data;
	xlen_t    rs2_data;
	logic     rf_wen;
	reg_idx_t rf_waddr;
	xlen_t    rf_wdata;

	npc_ifu u_ifu (.clk, .rst, .inst_addr, .inst_data, .dnpc, .pc_update, .illegal,
		.valid_if_id, .ready_if_id, .pc_if_id, .inst_if_id);

	npc_idu u_idu (.clk, .rst, .valid_if_id, .ready_if_id, .pc_if_id, .inst_if_id,
		.rs1_addr, .rs2_addr, .rs1_data, .rs2_data, .valid_id_ex, .ready_id_ex,
		.pc_id_ex, .op_a, .op_b, .imm, .alu_op, .rd, .is_branch, .is_jal, .is_jalr,
		.funct3, .illegal);

	npc_exu u_exu (.clk, .rst, .valid_id_ex, .ready_id_ex, .pc_id_ex, .op_a, .op_b,
		.imm, .alu_op, .rd, .is_branch, .is_jal, .is_jalr, .funct3, .dnpc, .pc_update,
		.valid_ex_wb, .ready_ex_wb, .pc_ex_wb, .wb_wen, .wb_rd, .wb_data);

	npc_wbu u_wbu (.clk, .rst, .valid_ex_wb, .ready_ex_wb, .pc_ex_wb, .wb_wen, .wb_rd,
		.wb_data, .rf_wen, .rf_waddr, .rf_wdata, .commit_valid, .commit_pc,
		.commit_wen, .commit_rd, .commit_data);

	// idu reads, wbu writes
	npc_regfile u_regfile (
		.clk    (clk),
		.rst    (rst),
		.raddr1 (rs1_addr),
		.raddr2 (rs2_addr),
		.rdata1 (rs1_data),
		.rdata2 (rs2_data),
		.wen    (rf_wen),
		.waddr  (rf_waddr),
		.wdata  (rf_wdata)
	);

endmodule

// File: source/npc_wbu.sv
// write back unit
`timescale 1ns/100ps

module npc_wbu (
	input  logic              clk,
	input  logic              rst,
	input  logic              valid_ex_wb,
	output logic              ready_ex_wb,
	input  npc_pkg::pc_t      pc_ex_wb,
	input  logic              wb_wen,
	input  npc_pkg::reg_idx_t wb_rd,
	input  npc_pkg::xlen_t    wb_data,
	output logic              rf_wen,
	output npc_pkg::reg_idx_t rf_waddr,
	output npc_pkg::xlen_t    rf_wdata,
	output logic              commit_valid,
	output npc_pkg::pc_t      commit_pc,
	output logic              commit_wen,
	output npc_pkg::reg_idx_t commit_rd,
	output npc_pkg::xlen_t    commit_data
);
	// last stage, never stalls
	assign ready_ex_wb = 1'b1;

	// regfile write in the accept cycle
	assign rf_wen   = valid_ex_wb && wb_wen;
	assign rf_waddr = wb_rd;
	assign rf_wdata = wb_data;

	// commit record, one cycle after the write
	always_ff @(posedge clk) begin
		if (rst) begin
			commit_valid <= 1'b0;
			commit_wen   <= 1'b0;
		end else begin
			commit_valid <= valid_ex_wb;
			commit_wen   <= valid_ex_wb && wb_wen;
		end
	end

	always_ff @(posedge clk) begin
		if (valid_ex_wb) begin
			commit_pc   <= pc_ex_wb;
			commit_rd   <= wb_rd;
			commit_data <= wb_data;
		end
	end

endmodule

// File: source/npc_exu.sv
// execute unit
`timescale 1ns/100ps

module npc_exu (
	input  logic              clk,
	input  logic              rst,
	input  logic              valid_id_ex,
	output logic              ready_id_ex,
	input  npc_pkg::pc_t      pc_id_ex,
	input  npc_pkg::xlen_t    op_a,
	input  npc_pkg::xlen_t    op_b,
	input  npc_pkg::xlen_t    imm,
	input  npc_pkg::alu_op_e  alu_op,
	input  npc_pkg::reg_idx_t rd,
	input  logic              is_branch,
	input  logic              is_jal,
	input  logic              is_jalr,
	input  logic [2:0]        funct3,
	output npc_pkg::pc_t      dnpc,
	output logic              pc_update,
	output logic              valid_ex_wb,
	input  logic              ready_ex_wb,
	output npc_pkg::pc_t      pc_ex_wb,
	output logic              wb_wen,
	output npc_pkg::reg_idx_t wb_rd,
	output npc_pkg::xlen_t    wb_data
);
	import npc_pkg::*;

	xlen_t alu_res;
	logic  cond;
	pc_t   pc_plus4;
	pc_t   target;
	pc_t   next_pc;
	logic  accept;

	// ****************************************
	// alu
	// ****************************************
	always_comb begin
		case (alu_op)
			ADD:     alu_res = op_a + op_b;
			SUB:     alu_res = op_a - op_b;
			SLL:     alu_res = op_a << op_b[5:0];
			SLT:     alu_res = xlen_t'($signed(op_a) < $signed(op_b));
			SLTU:    alu_res = xlen_t'(op_a < op_b);
			XOR:     alu_res = op_a ^ op_b;
			SRL:     alu_res = op_a >> op_b[5:0];
			SRA:     alu_res = xlen_t'($signed(op_a) >>> op_b[5:0]);
			OR:      alu_res = op_a | op_b;
			AND:     alu_res = op_a & op_b;
			default: alu_res = op_b;
		endcase
	end

	// branch compare on rs1 / rs2
	always_comb begin
		case (funct3)
			F3_BEQ:  cond = (op_a == op_b);
			F3_BNE:  cond = (op_a != op_b);
			F3_BLT:  cond = ($signed(op_a) < $signed(op_b));
			F3_BGE:  cond = ($signed(op_a) >= $signed(op_b));
			F3_BLTU: cond = (op_a < op_b);
			F3_BGEU: cond = (op_a >= op_b);
			default: cond = 1'b0;
		endcase
	end

	// next pc, jalr base is rs1
	assign pc_plus4 = pc_id_ex + 64'd4;
	assign target   = (is_jalr ? op_a : pc_id_ex) + imm;

	always_comb begin
		if (is_jalr) begin
			next_pc = {target[63:1], 1'b0};
		end else if (is_jal || (is_branch && cond)) begin
			next_pc = target;
		end else begin
			next_pc = pc_plus4;
		end
	end

	// ****************************************
	// ex/wb stage register
	// ****************************************
	assign ready_id_ex = !valid_ex_wb || ready_ex_wb;
	assign accept      = valid_id_ex && ready_id_ex;

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_ex_wb <= 1'b0;
			pc_update   <= 1'b0;
		end else begin
			// one cycle pulse back to ifu
			pc_update <= accept;
			if (accept) begin
				valid_ex_wb <= 1'b1;
			end else if (ready_ex_wb) begin
				valid_ex_wb <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			dnpc     <= next_pc;
			pc_ex_wb <= pc_id_ex;
			// branches and x0 targets write nothing
			wb_wen   <= !is_branch && (rd != 5'd0);
			wb_rd    <= rd;
			wb_data  <= (is_jal || is_jalr) ? pc_plus4 : alu_res;
		end
	end

endmodule

// File: source/npc_idu.sv
// instruction decode unit
`timescale 1ns/100ps

module npc_idu (
	input  logic               clk,
	input  logic               rst,
	input  logic               valid_if_id,
	output logic               ready_if_id,
	input  npc_pkg::pc_t       pc_if_id,
	input  npc_pkg::inst_t     inst_if_id,
	output npc_pkg::reg_idx_t  rs1_addr,
	output npc_pkg::reg_idx_t  rs2_addr,
	input  npc_pkg::xlen_t     rs1_data,
	input  npc_pkg::xlen_t     rs2_data,
	output logic               valid_id_ex,
	input  logic               ready_id_ex,
	output npc_pkg::pc_t       pc_id_ex,
	output npc_pkg::xlen_t     op_a,
	output npc_pkg::xlen_t     op_b,
	output npc_pkg::xlen_t     imm,
	output npc_pkg::alu_op_e   alu_op,
	output npc_pkg::reg_idx_t  rd,
	output logic               is_branch,
	output logic               is_jal,
	output logic               is_jalr,
	output logic [2:0]         funct3,
	output logic               illegal
);
	import npc_pkg::*;

	logic [6:0] opcode;
	logic [2:0] f3;
	logic [6:0] f7;
	xlen_t      imm_i;
	xlen_t      imm_u;
	xlen_t      imm_j;
	xlen_t      imm_b;
	alu_op_e    arith_op;
	logic       accept;
	logic       dec_illegal;
	logic       dec_branch;
	logic       dec_jal;
	logic       dec_jalr;
	xlen_t      dec_op_a;
	xlen_t      dec_op_b;
	xlen_t      dec_imm;
	alu_op_e    dec_alu_op;

	// ****************************************
	// field split and immediates
	// ****************************************
	assign opcode   = inst_if_id[6:0];
	assign f3       = inst_if_id[14:12];
	assign f7       = inst_if_id[31:25];
	assign rs1_addr = inst_if_id[19:15];
	assign rs2_addr = inst_if_id[24:20];

	assign imm_i = {{52{inst_if_id[31]}}, inst_if_id[31:20]};
	assign imm_u = {{32{inst_if_id[31]}}, inst_if_id[31:12], 12'b0};
	assign imm_j = {{44{inst_if_id[31]}}, inst_if_id[19:12], inst_if_id[20],
		inst_if_id[30:21], 1'b0};
	assign imm_b = {{52{inst_if_id[31]}}, inst_if_id[7], inst_if_id[30:25],
		inst_if_id[11:8], 1'b0};

	// funct3 to alu op, bit 30 picks sub / sra
	always_comb begin
		case (f3)
			3'b000:  arith_op = ((opcode == OPC_OP) && inst_if_id[30]) ? SUB : ADD;
			3'b001:  arith_op = SLL;
			3'b010:  arith_op = SLT;
			3'b011:  arith_op = SLTU;
			3'b100:  arith_op = XOR;
			3'b101:  arith_op = inst_if_id[30] ? SRA : SRL;
			3'b110:  arith_op = OR;
			default: arith_op = AND;
		endcase
	end

	// ****************************************
	// operand select and legality
	// ****************************************
	always_comb begin
		dec_illegal = 1'b0;
		dec_branch  = 1'b0;
		dec_jal     = 1'b0;
		dec_jalr    = 1'b0;
		dec_op_a    = rs1_data;
		dec_op_b    = rs2_data;
		dec_imm     = imm_i;
		dec_alu_op  = ADD;
		case (opcode)
			OPC_LUI: begin
				dec_op_b   = imm_u;
				dec_alu_op = PASS_B;
			end
			OPC_AUIPC: begin
				dec_op_a = pc_if_id;
				dec_op_b = imm_u;
			end
			OPC_JAL: begin
				// link value pc + 4
				dec_op_a = pc_if_id;
				dec_op_b = 64'd4;
				dec_imm  = imm_j;
				dec_jal  = 1'b1;
			end
			OPC_JALR: begin
				// op_a stays rs1 for the target
				dec_op_b    = 64'd4;
				dec_jalr    = 1'b1;
				dec_illegal = (f3 != 3'b000);
			end
			OPC_BRANCH: begin
				dec_imm     = imm_b;
				dec_branch  = 1'b1;
				dec_alu_op  = SUB;
				dec_illegal = (f3 == 3'b010) || (f3 == 3'b011);
			end
			OPC_OP_IMM: begin
				dec_op_b   = imm_i;
				dec_alu_op = arith_op;
				// rv64 shamt is 6 bits, upper six bits fixed
				if (f3 == 3'b001) begin
					dec_illegal = (inst_if_id[31:26] != 6'b000000);
				end else if (f3 == 3'b101) begin
					dec_illegal = (inst_if_id[31:26] != 6'b000000) &&
						(inst_if_id[31:26] != 6'b010000);
				end
			end
			OPC_OP: begin
				dec_alu_op  = arith_op;
				// only add/sub and srl/sra have an alternate form
				dec_illegal = (f7 != 7'b0000000) &&
					!((f7 == 7'b0100000) && ((f3 == 3'b000) || (f3 == 3'b101)));
			end
			default: dec_illegal = 1'b1;
		endcase
	end

	// ****************************************
	// id/ex stage register
	// ****************************************
	assign ready_if_id = !valid_id_ex || ready_id_ex;
	assign accept      = valid_if_id && ready_if_id;

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_id_ex <= 1'b0;
			illegal     <= 1'b0;
		end else begin
			// bad encodings are swallowed here
			if (accept && !dec_illegal) begin
				valid_id_ex <= 1'b1;
			end else if (ready_id_ex) begin
				valid_id_ex <= 1'b0;
			end
			if (accept && dec_illegal) begin
				illegal <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			pc_id_ex  <= pc_if_id;
			op_a      <= dec_op_a;
			op_b      <= dec_op_b;
			imm       <= dec_imm;
			alu_op    <= dec_alu_op;
			rd        <= inst_if_id[11:7];
			is_branch <= dec_branch;
			is_jal    <= dec_jal;
			is_jalr   <= dec_jalr;
			funct3    <= f3;
		end
	end

endmodule

// File: source/npc_ifu.sv
// instruction fetch unit
`timescale 1ns/100ps

module npc_ifu (
	input  logic           clk,
	input  logic           rst,
	output npc_pkg::pc_t   inst_addr,
	input  npc_pkg::inst_t inst_data,
	input  npc_pkg::pc_t   dnpc,
	input  logic           pc_update,
	input  logic           illegal,
	output logic           valid_if_id,
	input  logic           ready_if_id,
	output npc_pkg::pc_t   pc_if_id,
	output npc_pkg::inst_t inst_if_id
);
	import npc_pkg::*;

	pc_t          pc;
	fetch_state_e state;
	logic         capture;

	// imem address follows pc, only moves on pc_update
	assign inst_addr = pc;

	// take the word when fetching and the if/id slot is free
	assign capture = (state == FETCH) && (!valid_if_id || ready_if_id);

	// ****************************************
	// pc and fetch fsm
	// ****************************************
	always_ff @(posedge clk) begin
		if (rst) begin
			pc          <= RESET_PC;
			state       <= FETCH;
			valid_if_id <= 1'b0;
		end else begin
			if (illegal) begin
				// sticky stop
				state <= HALT;
			end else begin
				case (state)
					FETCH:    if (capture) state <= WAIT_UPD;
					WAIT_UPD: begin
						// one in flight, wait for exu next pc
						if (pc_update) begin
							pc    <= dnpc;
							state <= FETCH;
						end
					end
					default:  state <= HALT;
				endcase
			end
			// if/id valid, drained by idu
			if (capture) begin
				valid_if_id <= 1'b1;
			end else if (ready_if_id) begin
				valid_if_id <= 1'b0;
			end
		end
	end

	// if/id payload
	always_ff @(posedge clk) begin
		if (capture) begin
			pc_if_id   <= pc;
			inst_if_id <= inst_data;
		end
	end

endmodule

// File: source/npc_regfile.sv
// general purpose register file
`timescale 1ns/100ps

module npc_regfile (
	input  logic              clk,
	input  logic              rst,
	input  npc_pkg::reg_idx_t raddr1,
	input  npc_pkg::reg_idx_t raddr2,
	output npc_pkg::xlen_t    rdata1,
	output npc_pkg::xlen_t    rdata2,
	input  logic              wen,
	input  npc_pkg::reg_idx_t waddr,
	input  npc_pkg::xlen_t    wdata
);
	import npc_pkg::*;

	// storage for x1 to x31 only
	xlen_t regs [1:31];

	// single write port
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && (waddr != 5'd0)) begin
			// x0 writes dropped here
			regs[waddr] <= wdata;
		end
	end

	// two async read ports
	// x0 always reads zero
	assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

// File: source/npc_pkg.sv
// npc shared definitions
package npc_pkg;

	// ****************************************
	// datapath widths
	// ****************************************

	// register and alu value
	typedef logic [63:0] xlen_t;
	// instruction address
	typedef logic [63:0] pc_t;
	// raw instruction word
	typedef logic [31:0] inst_t;
	// register index
	typedef logic [4:0]  reg_idx_t;

	// alu operations
	typedef enum logic [3:0] {
		ADD,
		SUB,
		SLL,
		SLT,
		SLTU,
		XOR,
		SRL,
		SRA,
		OR,
		AND,
		PASS_B
	} alu_op_e;

	// ifu states
	typedef enum logic [1:0] {
		FETCH,
		WAIT_UPD,
		HALT
	} fetch_state_e;

	// first fetch address
	localparam pc_t RESET_PC = 64'h0000_0000_8000_0000;

	// ****************************************
	// rv64i major opcodes
	// ****************************************
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;

	// branch funct3 codes
	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

endpackage
